// ==== all.f ====
+incdir+source
source/bus_pkg.sv
source/link_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/frame_decoder.sv
source/bus_master.sv
source/frame_encoder.sv
source/peripheral_bank.sv
source/uniboard_top.sv
bench/uniboard_checker.sv
bench/tb_uniboard.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the uniboard testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module tb_uniboard -Mdir obj_dir; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_uniboard)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx 'Result: PASSED'; then
	exit 0
fi
exit 1

// ==== bench/tb_uniboard.sv ====
`include "uniboard_defs.svh"
`default_nettype none

module tb_uniboard;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_FRAMES = 60;
	// longest reply is 14 escaped bytes of 10 bits
	localparam int REPLY_TIMEOUT = 25 * 10 * `UB_BAUD_DIV;
	localparam int QUIET_CLOCKS = 20 * 10 * `UB_BAUD_DIV;

	logic clk_12MHz = 1'b0;
	logic reset;
	logic uart_rx;
	logic uart_tx;
	int checker_errors;
	int replies_done;
	int pending_bytes;
	int bench_errors;
	int frames_sent;
	// payload before escaping, up to two bytes past the limit
	logic [7:0] payload [8];
	int payload_len;

	always #10 clk_12MHz = ~clk_12MHz;

	uniboard_top u_uniboard_top (.clk_12MHz(clk_12MHz), .reset(reset),
		.uart_rx(uart_rx), .uart_tx(uart_tx));

	uniboard_checker u_checker (.clk_12MHz(clk_12MHz), .reset(reset),
		.uart_rx(uart_rx), .uart_tx(uart_tx), .error_count(checker_errors),
		.replies_done(replies_done), .pending_bytes(pending_bytes));

	// 8N1, lsb first
	task automatic send_serial(input logic [7:0] b);
		@(negedge clk_12MHz);
		uart_rx = 1'b0;
		repeat (`UB_BAUD_DIV) @(negedge clk_12MHz);
		for (int i = 0; i < 8; i++)
		begin
			uart_rx = b[i];
			repeat (`UB_BAUD_DIV) @(negedge clk_12MHz);
		end
		uart_rx = 1'b1;
		repeat (`UB_BAUD_DIV) @(negedge clk_12MHz);
	endtask

	// framing characters forced in about a third of the time
	function automatic logic [7:0] random_byte();
		case ($urandom % 9)
			0: return `UB_START_BYTE;
			1: return `UB_END_BYTE;
			2: return `UB_ESC_BYTE;
			default: return 8'($urandom);
		endcase
	endfunction

	task automatic fill_random_payload();
		int pick;
		pick = $urandom % 10;
		if (pick == 0)
			payload_len = $urandom % 2;
		else if (pick == 1)
			payload_len = 7 + $urandom % 2;
		else if (pick < 4)
			payload_len = 2 + $urandom % 4;
		else
			payload_len = 6;
		// mostly the two mapped ids, sometimes anything
		if ($urandom % 4 == 0)
			payload[0] = random_byte();
		else
			payload[0] = {($urandom % 3 == 0), 7'(1 + $urandom % 2)};
		if ($urandom % 5 == 0)
			payload[1] = random_byte();
		else
			payload[1] = 8'($urandom % `UB_REGS_PER_PERIPH);
		for (int i = 2; i < 8; i++)
			payload[i] = random_byte();
	endtask

	task automatic send_frame();
		send_serial(`UB_START_BYTE);
		for (int i = 0; i < payload_len; i++)
		begin
			if (payload[i] == `UB_START_BYTE || payload[i] == `UB_END_BYTE ||
				payload[i] == `UB_ESC_BYTE)
				send_serial(`UB_ESC_BYTE);
			send_serial(payload[i]);
		end
		send_serial(`UB_END_BYTE);
		frames_sent++;
	endtask

	// junk between frames
	task automatic send_noise();
		int n;
		logic [7:0] b;
		n = 1 + $urandom % 3;
		for (int i = 0; i < n; i++)
		begin
			b = 8'($urandom);
			// a stray start byte would open a frame
			if (b == `UB_START_BYTE)
				b = 8'hA5;
			send_serial(b);
		end
	endtask

	task automatic await_reply(input int start);
		int waited;
		waited = 0;
		while (replies_done == start && waited < REPLY_TIMEOUT)
		begin
			@(negedge clk_12MHz);
			waited++;
		end
		if (replies_done == start)
		begin
			$display("no reply to frame %0d (header 0x%02h) within %0d clocks",
				frames_sent, payload[0], REPLY_TIMEOUT);
			bench_errors++;
		end
	endtask

	// short frame, the board must stay silent
	task automatic await_quiet(input int start);
		int waited;
		waited = 0;
		while (replies_done == start && waited < QUIET_CLOCKS)
		begin
			@(negedge clk_12MHz);
			waited++;
		end
		if (replies_done != start)
		begin
			$display("reply seen to short frame %0d of %0d payload bytes",
				frames_sent, payload_len);
			bench_errors++;
		end
	endtask

	task automatic run_frame();
		int start;
		start = replies_done;
		send_frame();
		if (payload_len >= 2)
			await_reply(start);
		else
			await_quiet(start);
	endtask

	initial
	begin
		uart_rx = 1'b1;
		reset = 1'b1;
		bench_errors = 0;
		frames_sent = 0;
		payload_len = 0;
		void'($urandom(70));
		repeat (16) @(negedge clk_12MHz);
		reset = 1'b0;
		repeat (4) @(negedge clk_12MHz);

		// fresh registers read zero
		for (int id = 1; id <= 2; id++)
			for (int a = 0; a < `UB_REGS_PER_PERIPH; a++)
			begin
				payload[0] = {1'b1, 7'(id)};
				payload[1] = 8'(a);
				payload_len = 2;
				run_frame();
			end

		for (int n = 0; n < NUM_FRAMES; n++)
		begin
			if ($urandom % 4 == 0)
				send_noise();
			fill_random_payload();
			run_frame();
			// read back a write now and then
			if (payload_len >= 2 && !payload[0][7] && $urandom % 2 == 0)
			begin
				payload[0][7] = 1'b1;
				payload_len = 2;
				run_frame();
			end
		end

		repeat (4 * `UB_BAUD_DIV) @(negedge clk_12MHz);
		if (pending_bytes != 0)
		begin
			$display("%0d reply bytes never arrived", pending_bytes);
			bench_errors++;
		end

		$display("frames %0d, replies %0d, checker errors %0d, bench errors %0d",
			frames_sent, replies_done, checker_errors, bench_errors);
		if (checker_errors == 0 && bench_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/uniboard_checker.sv ====
`include "uniboard_defs.svh"
`default_nettype none

// recovers bytes from one 8N1 line, sampled at bit centers
module serial_sniffer
(
	input logic clk_12MHz,
	input logic reset,
	input logic line,
	output logic [7:0] data,
	output logic valid,
	output logic stop_err
);
	timeunit 1ns;
	timeprecision 1ps;

	logic active;
	int wait_cnt;
	// 0 is the start bit, 1..8 data, 9 stop
	int nbit;
	logic [7:0] shift;

	always @(posedge clk_12MHz)
	begin
		valid <= 1'b0;
		stop_err <= 1'b0;
		if (reset)
			active <= 1'b0;
		else if (!active)
		begin
			// first low sample, start bit just began
			if (!line)
			begin
				active <= 1'b1;
				wait_cnt <= `UB_BAUD_DIV / 2 - 1;
				nbit <= 0;
			end
		end
		else if (wait_cnt != 0)
			wait_cnt <= wait_cnt - 1;
		else
		begin
			wait_cnt <= `UB_BAUD_DIV - 1;
			nbit <= nbit + 1;
			if (nbit == 0)
			begin
				// glitch, not a real start
				if (line)
					active <= 1'b0;
			end
			else if (nbit <= 8)
				shift <= {line, shift[7:1]};
			else
			begin
				active <= 1'b0;
				data <= shift;
				valid <= line;
				stop_err <= !line;
			end
		end
	end

endmodule

module uniboard_checker
(
	input logic clk_12MHz,
	input logic reset,
	input logic uart_rx,
	input logic uart_tx,
	output int error_count,
	output int replies_done,
	output int pending_bytes
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ST_IDLE = 0;
	localparam int ST_FRAME = 1;
	localparam int ST_ESC = 2;

	logic [7:0] host_byte;
	logic host_valid;
	logic [7:0] board_byte;
	logic board_valid;
	logic board_stop_err;

	// host side frame parser
	int state;
	int count;
	logic [7:0] pay [`UB_PAYLOAD_BYTES];
	// register model, ids 1 and 2
	logic [31:0] regs [2][`UB_REGS_PER_PERIPH];
	// reply bytes still to come, bit 8 marks the end byte
	logic [8:0] exp_q [$];

	serial_sniffer u_host_sniffer (.clk_12MHz(clk_12MHz), .reset(reset), .line(uart_rx),
		.data(host_byte), .valid(host_valid), .stop_err());

	serial_sniffer u_board_sniffer (.clk_12MHz(clk_12MHz), .reset(reset), .line(uart_tx),
		.data(board_byte), .valid(board_valid), .stop_err(board_stop_err));

	function automatic logic is_special(input logic [7:0] b);
		return (b == `UB_START_BYTE) || (b == `UB_END_BYTE) || (b == `UB_ESC_BYTE);
	endfunction

	task automatic push_escaped(input logic [7:0] b);
		if (is_special(b))
			exp_q.push_back({1'b0, `UB_ESC_BYTE});
		exp_q.push_back({1'b0, b});
	endtask

	// one complete frame, apply it to the model and queue the reply
	task automatic run_command();
		logic [31:0] wdata;
		logic [6:0] id;
		logic [7:0] addr;
		logic mapped;
		logic [31:0] word;
		wdata = '0;
		// absent data bytes are zero
		for (int i = 0; i < 4; i++)
			if (count > i + 2)
				wdata[8 * i +: 8] = pay[i + 2];
		id = pay[0][6:0];
		addr = pay[1];
		mapped = (id == 7'd1 || id == 7'd2) && (int'(addr) < `UB_REGS_PER_PERIPH);
		if (mapped && !pay[0][7])
			regs[int'(id) - 1][int'(addr)] = wdata;
		exp_q.push_back({1'b0, `UB_START_BYTE});
		push_escaped(pay[0]);
		push_escaped(pay[1]);
		// dummy answer carries no data
		if (mapped)
		begin
			word = regs[int'(id) - 1][int'(addr)];
			for (int i = 0; i < 4; i++)
				push_escaped(word[8 * i +: 8]);
		end
		exp_q.push_back({1'b1, `UB_END_BYTE});
	endtask

	task automatic store_byte(input logic [7:0] b);
		// extra payload dropped
		if (count < `UB_PAYLOAD_BYTES)
		begin
			pay[count] = b;
			count++;
		end
	endtask

	task automatic take_host_byte(input logic [7:0] b);
		case (state)
			ST_IDLE:
			begin
				if (b == `UB_START_BYTE)
				begin
					state = ST_FRAME;
					count = 0;
				end
			end
			ST_FRAME:
			begin
				if (b == `UB_START_BYTE)
					count = 0;
				else if (b == `UB_END_BYTE)
				begin
					state = ST_IDLE;
					// short frames get no answer
					if (count >= 2)
						run_command();
				end
				else if (b == `UB_ESC_BYTE)
					state = ST_ESC;
				else
					store_byte(b);
			end
			default:
			begin
				store_byte(b);
				state = ST_FRAME;
			end
		endcase
	endtask

	task automatic check_board_byte(input logic [7:0] b);
		logic [8:0] e;
		if (exp_q.size() == 0)
		begin
			$display("unexpected byte 0x%02h on uart_tx at %0d ns, no reply was due", b, $time);
			error_count++;
		end
		else
		begin
			e = exp_q.pop_front();
			if (b != e[7:0])
			begin
				$display("Mismatch at %0d ns: uart_tx got 0x%02h expected 0x%02h",
					$time, b, e[7:0]);
				error_count++;
			end
			if (e[8])
				replies_done++;
		end
	endtask

	always @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state = ST_IDLE;
			count = 0;
			exp_q.delete();
			error_count = 0;
			replies_done = 0;
			pending_bytes = 0;
			for (int p = 0; p < 2; p++)
				for (int r = 0; r < `UB_REGS_PER_PERIPH; r++)
					regs[p][r] = '0;
		end
		else
		begin
			if (host_valid)
				take_host_byte(host_byte);
			if (board_valid)
				check_board_byte(board_byte);
			if (board_stop_err)
			begin
				$display("stop bit missing on uart_tx at %0d ns", $time);
				error_count++;
			end
			pending_bytes = exp_q.size();
		end
	end

endmodule

`default_nettype wire

// ==== source/uniboard_top.sv ====
`default_nettype none

module uniboard_top
	import bus_pkg::*;
	import link_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic uart_rx,
	output logic uart_tx
);

	logic [7:0] rx_byte;
	logic rx_valid;
	bus_cmd_t cmd;
	logic cmd_valid;
	logic cmd_ready;
	bus_req_t req;
	bus_rsp_t rsp;
	reply_t reply;
	logic reply_valid;
	logic reply_ready;
	logic [7:0] tx_byte;
	logic tx_valid;
	logic tx_ready;

	// host bytes in
	uart_rx u_uart_rx (.clk_12MHz(clk_12MHz), .reset(reset), .rx(uart_rx),
		.rx_byte(rx_byte), .rx_valid(rx_valid));

	frame_decoder u_frame_decoder (.clk_12MHz(clk_12MHz), .reset(reset),
		.rx_byte(rx_byte), .rx_valid(rx_valid),
		.cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready));

	// select sequencing and readback
	bus_master u_bus_master (.clk_12MHz(clk_12MHz), .reset(reset),
		.cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.req(req), .rsp(rsp),
		.reply(reply), .reply_valid(reply_valid), .reply_ready(reply_ready));

	peripheral_bank u_peripheral_bank (.clk_12MHz(clk_12MHz), .reset(reset),
		.req(req), .rsp(rsp));

	// reply frame back to the host
	frame_encoder u_frame_encoder (.clk_12MHz(clk_12MHz), .reset(reset),
		.reply(reply), .reply_valid(reply_valid), .reply_ready(reply_ready),
		.tx_byte(tx_byte), .tx_valid(tx_valid), .tx_ready(tx_ready));

	uart_tx u_uart_tx (.clk_12MHz(clk_12MHz), .reset(reset),
		.tx_byte(tx_byte), .tx_valid(tx_valid), .tx_ready(tx_ready), .tx(uart_tx));

endmodule

`default_nettype wire

// ==== source/peripheral_bank.sv ====
`include "uniboard_defs.svh"
`default_nettype none

module peripheral_bank
	import bus_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input bus_req_t req,
	output bus_rsp_t rsp
);

	// register peripherals sit on ids 1 and 2
	localparam int FIRST_ID = 1;
	localparam int NUM_MAPPED = 2;
	localparam int AW = $clog2(`UB_REGS_PER_PERIPH);

	logic [31:0] regs [NUM_MAPPED][`UB_REGS_PER_PERIPH];
	logic [NUM_MAPPED-1:0] sel;
	logic [NUM_MAPPED-1:0] sel_q;
	logic in_range;
	logic [AW-1:0] idx;

	assign sel = req.select[FIRST_ID +: NUM_MAPPED];
	assign in_range = (32'(req.addr) < `UB_REGS_PER_PERIPH);
	assign idx = req.addr[AW-1:0];

	// write on the rising edge of select
	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			sel_q <= '0;
			for (int p = 0; p < NUM_MAPPED; p++)
				for (int r = 0; r < `UB_REGS_PER_PERIPH; r++)
					regs[p][r] <= '0;
		end
		else
		begin
			sel_q <= sel;
			for (int p = 0; p < NUM_MAPPED; p++)
				if (sel[p] && !sel_q[p] && !req.rw && in_range)
					regs[p][idx] <= req.wdata;
		end
	end

	// anything unmapped answers like the dummy peripheral, size 0 and data 0
	always_comb
	begin
		rsp.reg_size = 3'd0;
		rsp.rdata = '0;
		for (int p = 0; p < NUM_MAPPED; p++)
			if (sel[p] && in_range)
			begin
				rsp.reg_size = 3'd4;
				rsp.rdata = regs[p][idx];
			end
	end

endmodule

`default_nettype wire

// ==== source/frame_encoder.sv ====
`include "uniboard_defs.svh"
`default_nettype none

module frame_encoder
	import link_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input reply_t reply,
	input logic reply_valid,
	output logic reply_ready,
	output logic [7:0] tx_byte,
	output logic tx_valid,
	input logic tx_ready
);

	typedef enum logic [1:0] {ST_IDLE, ST_SEND, ST_DRAIN} state_t;

	state_t state;
	reply_t reply_q;
	// frame position: start, header, address, data..., end
	logic [3:0] idx;
	logic [3:0] last_idx;
	logic [3:0] data_off;
	logic [2:0] size;
	logic esc_sent;
	logic [7:0] cur;
	logic framing;
	logic need_esc;
	logic slot_free;

	assign reply_ready = (state == ST_IDLE);
	assign slot_free = !tx_valid || tx_ready;
	// the data word has four bytes at most
	assign size = (reply_q.reg_size > 3'd4) ? 3'd4 : reply_q.reg_size;
	assign last_idx = 4'd3 + {1'b0, size};
	assign data_off = idx - 4'd3;
	// start and end bytes go out bare
	assign framing = (idx == 4'd0) || (idx == last_idx);
	assign need_esc = !framing && !esc_sent && ((cur == `UB_START_BYTE) ||
		(cur == `UB_END_BYTE) || (cur == `UB_ESC_BYTE));

	always_comb
	begin
		if (idx == 4'd0)
			cur = `UB_START_BYTE;
		else if (idx == 4'd1)
			cur = reply_q.header;
		else if (idx == 4'd2)
			cur = reply_q.addr;
		else if (idx == last_idx)
			cur = `UB_END_BYTE;
		else
			cur = reply_q.data.bytes[data_off[1:0]];
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			idx <= '0;
			esc_sent <= 1'b0;
			tx_valid <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (reply_valid)
					begin
						idx <= '0;
						esc_sent <= 1'b0;
						state <= ST_SEND;
					end
				end
				ST_SEND:
				begin
					// next byte once the last one is taken
					if (slot_free)
					begin
						tx_valid <= 1'b1;
						if (need_esc)
							esc_sent <= 1'b1;
						else
						begin
							esc_sent <= 1'b0;
							if (idx == last_idx)
								state <= ST_DRAIN;
							else
								idx <= idx + 1'b1;
						end
					end
				end
				default:
				begin
					// end byte taken, frame done
					if (tx_ready)
					begin
						tx_valid <= 1'b0;
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (state == ST_IDLE && reply_valid)
			reply_q <= reply;
		if (state == ST_SEND && slot_free)
			tx_byte <= need_esc ? `UB_ESC_BYTE : cur;
	end

	// transmitter may be busy for a full character
	assert property (@(posedge clk_12MHz) disable iff (reset)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_byte));

endmodule

`default_nettype wire

// ==== source/bus_master.sv ====
`include "uniboard_defs.svh"
`default_nettype none

module bus_master
	import bus_pkg::*;
	import link_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input bus_cmd_t cmd,
	input logic cmd_valid,
	output logic cmd_ready,
	output bus_req_t req,
	input bus_rsp_t rsp,
	output reply_t reply,
	output logic reply_valid,
	input logic reply_ready
);

	typedef enum logic [2:0] {ST_IDLE, ST_ADDR, ST_SETUP, ST_SEL, ST_HOLD, ST_REPLY} state_t;

	state_t state;
	// write pass still pending, read-back follows it
	logic writing;
	bus_cmd_t cmd_q;
	cmd_header_t cmd_hdr;
	cmd_header_t q_hdr;
	logic [`UB_NUM_PERIPH-1:0] sel_vec;
	logic [`UB_NUM_PERIPH-1:0] select_q;
	logic [7:0] addr_q;
	logic rw_q;
	logic [31:0] wdata_q;

	assign cmd_hdr = cmd.header;
	assign q_hdr = cmd_q.header;
	assign cmd_ready = (state == ST_IDLE);

	// ids past the select vector raise nothing
	always_comb
	begin
		sel_vec = '0;
		if (32'(q_hdr.id) < `UB_NUM_PERIPH)
			sel_vec = `UB_NUM_PERIPH'(1) << q_hdr.id;
	end

	always_comb
	begin
		req.select = select_q;
		req.addr = addr_q;
		req.rw = rw_q;
		req.wdata = wdata_q;
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			writing <= 1'b0;
			select_q <= '0;
			reply_valid <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (cmd_valid)
					begin
						writing <= !cmd_hdr.rd;
						state <= ST_ADDR;
					end
				end
				// address and rw go out this edge, one cycle ahead of select
				ST_ADDR:
					state <= ST_SETUP;
				ST_SETUP:
				begin
					select_q <= sel_vec;
					state <= ST_SEL;
				end
				ST_SEL:
					state <= ST_HOLD;
				ST_HOLD:
				begin
					// second select cycle, read data is settled
					select_q <= '0;
					if (writing)
					begin
						writing <= 1'b0;
						state <= ST_ADDR;
					end
					else
					begin
						reply_valid <= 1'b1;
						state <= ST_REPLY;
					end
				end
				default:
				begin
					if (reply_ready)
					begin
						reply_valid <= 1'b0;
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (state == ST_IDLE && cmd_valid)
			cmd_q <= cmd;
		if (state == ST_ADDR)
		begin
			addr_q <= cmd_q.addr;
			rw_q <= !writing;
			wdata_q <= cmd_q.data.word;
		end
		// capture on the read pass only
		if (state == ST_HOLD && !writing)
		begin
			reply.header <= q_hdr;
			reply.addr <= cmd_q.addr;
			reply.reg_size <= rsp.reg_size;
			reply.data.word <= rsp.rdata;
		end
	end

	// at most one peripheral, address and direction steady while selected
	assert property (@(posedge clk_12MHz) disable iff (reset)
		|req.select |-> $onehot(req.select) && $stable(req.addr) && $stable(req.rw));

endmodule

`default_nettype wire

// ==== source/frame_decoder.sv ====
`include "uniboard_defs.svh"
`default_nettype none

module frame_decoder
	import bus_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic [7:0] rx_byte,
	input logic rx_valid,
	output bus_cmd_t cmd,
	output logic cmd_valid,
	input logic cmd_ready
);

	typedef enum logic [1:0] {ST_IDLE, ST_FRAME, ST_ESC} state_t;

	state_t state;
	logic [7:0] payload [`UB_PAYLOAD_BYTES];
	logic [2:0] count;
	logic plain;
	logic store;
	logic frame_end;
	logic load;
	bus_cmd_t next_cmd;

	// not a framing character
	assign plain = (rx_byte != `UB_START_BYTE) && (rx_byte != `UB_END_BYTE) &&
		(rx_byte != `UB_ESC_BYTE);
	// escaped bytes are data whatever they are
	assign store = rx_valid && ((state == ST_ESC) || (state == ST_FRAME && plain));
	assign frame_end = rx_valid && (state == ST_FRAME) && (rx_byte == `UB_END_BYTE);
	// short frames dropped, and so is a frame finishing while a command waits
	assign load = frame_end && (count >= 3'd2) && (!cmd_valid || cmd_ready);

	// missing data bytes read as zero
	always_comb
	begin
		next_cmd.header = payload[0];
		next_cmd.addr = payload[1];
		for (int i = 0; i < `UB_PAYLOAD_BYTES - 2; i++)
			next_cmd.data.bytes[i] = (count > i + 2) ? payload[i + 2] : 8'h00;
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			count <= '0;
			cmd_valid <= 1'b0;
		end
		else
		begin
			if (cmd_valid && cmd_ready)
				cmd_valid <= 1'b0;
			if (load)
				cmd_valid <= 1'b1;
			// bytes past the sixth are thrown away
			if (store && count < 3'(`UB_PAYLOAD_BYTES))
				count <= count + 1'b1;
			if (rx_valid)
			begin
				case (state)
					ST_IDLE:
					begin
						// anything but a start byte is noise here
						if (rx_byte == `UB_START_BYTE)
						begin
							state <= ST_FRAME;
							count <= '0;
						end
					end
					ST_FRAME:
					begin
						// unescaped start inside a frame begins a new one
						if (rx_byte == `UB_START_BYTE)
							count <= '0;
						else if (rx_byte == `UB_END_BYTE)
							state <= ST_IDLE;
						else if (rx_byte == `UB_ESC_BYTE)
							state <= ST_ESC;
					end
					default:
						state <= ST_FRAME;
				endcase
			end
		end
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (store && count < 3'(`UB_PAYLOAD_BYTES))
			payload[count] <= rx_byte;
		if (load)
			cmd <= next_cmd;
	end

	// held command must not change under a stalled master
	assert property (@(posedge clk_12MHz) disable iff (reset)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd));

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
`include "uniboard_defs.svh"
`default_nettype none

module uart_tx
(
	input logic clk_12MHz,
	input logic reset,
	input logic [7:0] tx_byte,
	input logic tx_valid,
	output logic tx_ready,
	output logic tx
);

	// line image, bit 0 is on the wire
	// refills with ones so the line idles high
	logic [9:0] frame;
	logic busy;
	logic [$clog2(`UB_BAUD_DIV)-1:0] baud_cnt;
	logic [3:0] bit_cnt;

	assign tx = frame[0];
	assign tx_ready = !busy;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			frame <= '1;
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end
		else if (!busy)
		begin
			// stop, data, start
			if (tx_valid)
			begin
				frame <= {1'b1, tx_byte, 1'b0};
				busy <= 1'b1;
				baud_cnt <= '0;
				bit_cnt <= '0;
			end
		end
		else if (baud_cnt == `UB_BAUD_DIV - 1)
		begin
			baud_cnt <= '0;
			frame <= {1'b1, frame[9:1]};
			bit_cnt <= bit_cnt + 1'b1;
			// tenth bit time done, end of stop bit
			if (bit_cnt == 4'd9)
				busy <= 1'b0;
		end
		else
			baud_cnt <= baud_cnt + 1'b1;
	end

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
`include "uniboard_defs.svh"
`default_nettype none

module uart_rx
(
	input logic clk_12MHz,
	input logic reset,
	input logic rx,
	output logic [7:0] rx_byte,
	output logic rx_valid
);

	typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} state_t;

	state_t state;
	logic [$clog2(`UB_BAUD_DIV)-1:0] baud_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	// sample points within a bit
	logic half_bit;
	logic full_bit;

	assign half_bit = (baud_cnt == `UB_BAUD_DIV / 2 - 1);
	assign full_bit = (baud_cnt == `UB_BAUD_DIV - 1);
	// shifter stops moving once the last data bit is in
	assign rx_byte = shift;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			baud_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_valid <= 1'b0;
			baud_cnt <= baud_cnt + 1'b1;
			case (state)
				ST_IDLE:
				begin
					baud_cnt <= '0;
					// falling edge starts a character
					if (!rx)
						state <= ST_START;
				end
				ST_START:
				begin
					// line back high at mid start bit, just a glitch
					if (half_bit)
					begin
						baud_cnt <= '0;
						bit_cnt <= '0;
						state <= rx ? ST_IDLE : ST_DATA;
					end
				end
				ST_DATA:
				begin
					// counter now lands on the middle of each bit
					if (full_bit)
					begin
						baud_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= ST_STOP;
					end
				end
				default:
				begin
					// bad stop bit drops the byte
					if (full_bit)
					begin
						rx_valid <= rx;
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// lsb first, so shift in from the top
	always_ff @(posedge clk_12MHz)
	begin
		if (state == ST_DATA && full_bit)
			shift <= {rx, shift[7:1]};
	end

endmodule

`default_nettype wire

// ==== source/link_pkg.sv ====
`default_nettype none

package link_pkg;

	// first payload byte of a frame
	typedef struct packed {
		logic rd;
		logic [6:0] id;
	} cmd_header_t;

	// everything the encoder needs for one reply frame
	typedef struct packed {
		cmd_header_t header;
		logic [7:0] addr;
		logic [2:0] reg_size;
		bus_pkg::data_word_u data;
	} reply_t;

endpackage

`default_nettype wire

// ==== source/bus_pkg.sv ====
`include "uniboard_defs.svh"
`default_nettype none

package bus_pkg;

	// one register value
	// bus side moves it as a word, serial side as bytes, bytes[0] is the LSB
	typedef union packed {
		logic [31:0] word;
		logic [3:0][7:0] bytes;
	} data_word_u;

	// command as the decoder hands it over
	// header kept as the raw first payload byte
	typedef struct packed {
		logic [7:0] header;
		logic [7:0] addr;
		data_word_u data;
	} bus_cmd_t;

	// master to peripherals
	// rw is 0 for write, 1 for read
	typedef struct packed {
		logic [`UB_NUM_PERIPH-1:0] select;
		logic [7:0] addr;
		logic rw;
		logic [31:0] wdata;
	} bus_req_t;

	// peripherals to master, size in bytes
	typedef struct packed {
		logic [2:0] reg_size;
		logic [31:0] rdata;
	} bus_rsp_t;

endpackage

`default_nettype wire

// ==== source/uniboard_defs.svh ====
`ifndef UNIBOARD_DEFS_SVH
`define UNIBOARD_DEFS_SVH

// clocks per serial bit
// 12 MHz / 12 gives 1 Mbaud on the host link
`define UB_BAUD_DIV 12

// framing characters of the host protocol
`define UB_START_BYTE 8'h01
`define UB_END_BYTE 8'h17

// prefix ahead of any payload byte that looks like a framing character
`define UB_ESC_BYTE 8'h1B

// header, register address, then up to four data bytes
`define UB_PAYLOAD_BYTES 6

// width of the peripheral select vector
`define UB_NUM_PERIPH 8

// 32-bit registers in each mapped peripheral
`define UB_REGS_PER_PERIPH 4

`endif
